//--- Bender.yml
package:
  name: sd_autotest

sources:
  - hdl/sd_autotest_pkg.sv
  - hdl/vector_loader.sv
  - hdl/result_writer.sv
  - hdl/autotest_ctrl.sv
  - hdl/sd_autotest.sv
  - target: test
    files:
      - bench/sd_host_model.sv
      - bench/cipher_stub.sv
      - bench/tb_sd_autotest.sv

//--- bench/cipher_stub.sv
// cipher stand-in: fixed latency out of reset, block XOR key as the transform
`timescale 1ns/10ps

module cipher_stub (
  input  logic                    clk,
  input  logic                    rst,
  input  sd_autotest_pkg::block_t block_i,
  input  sd_autotest_pkg::key_t   key_i,
  input  logic                    decrypt_i,
  output sd_autotest_pkg::block_t block_o,
  output logic                    end_enc_o,
  output logic                    end_dec_o
);

  localparam int LATENCY = 20;

  int cycles = 0;

  always @(posedge clk) begin
    if (rst) begin
      cycles <= 0;
    end else if (cycles < LATENCY) begin
      cycles <= cycles + 1;
    end
  end

  assign block_o   = decrypt_i ? (block_i ^ key_i[79:16]) : (block_i ^ key_i[63:0]);
  assign end_enc_o = !decrypt_i && (cycles == LATENCY);
  assign end_dec_o = decrypt_i && (cycles == LATENCY);

endmodule

//--- bench/sd_host_model.sv
// SPI SD host model: sector memory behind the busy/strobe handshake with random busy stretches
`timescale 1ns/10ps

module sd_host_model (
  input  logic                      clk,
  input  logic                      spi_rst_i,
  input  logic                      r_block_i,
  input  logic                      r_byte_i,
  input  logic                      w_block_i,
  input  logic                      w_byte_i,
  input  sd_autotest_pkg::sd_addr_t block_addr_i,
  input  sd_autotest_pkg::byte_t    data_in_i,
  input  int                        busy_max_i,
  output logic                      busy_o,
  output sd_autotest_pkg::byte_t    data_out_o
);

  import sd_autotest_pkg::*;

  // eight sectors from START_BLOCK on
  byte_t mem [8*SECTOR_BYTES];
  byte_t wbuf [SECTOR_BYTES];
  int    base;
  int    idx;

  function automatic int sector_base(sd_addr_t addr);
    return int'((addr - START_BLOCK) % 8) * SECTOR_BYTES;
  endfunction

  task automatic busy_stretch();
    int unsigned len;
    len = 1 + ($urandom % busy_max_i);
    busy_o = 1'b1;
    repeat (len) @(negedge clk);
    busy_o = 1'b0;
  endtask

  initial begin
    busy_o     = 1'b0;
    data_out_o = '0;
    void'($urandom(32'h5b19_8d63));
    forever begin
      @(negedge clk);
      if (spi_rst_i) begin
        busy_stretch();
      end else if (r_block_i) begin
        base = sector_base(block_addr_i);
        idx  = 0;
        busy_stretch();
        data_out_o = mem[base];
        while (r_block_i) begin
          @(negedge clk);
          if (r_byte_i && idx < SECTOR_BYTES - 1) begin
            idx++;
            busy_stretch();
            data_out_o = mem[base + idx];
          end
        end
      end else if (w_block_i) begin
        base = sector_base(block_addr_i);
        idx  = 0;
        busy_stretch();
        while (w_block_i) begin
          @(negedge clk);
          if (w_byte_i && idx < SECTOR_BYTES) begin
            wbuf[idx] = data_in_i;
            idx++;
            busy_stretch();
          end
        end
        // sector is committed once w_block drops
        for (int i = 0; i < idx; i++) begin
          mem[base + i] = wbuf[i];
        end
      end
    end
  end

endmodule

//--- bench/tb_sd_autotest.sv
// testbench for the cipher self-test sequencer with SD host model and cipher stub
`timescale 1ns/10ps

module tb_sd_autotest;

  import sd_autotest_pkg::*;

  localparam int BUSY_SHORT  = 3;
  localparam int BUSY_LONG   = 40;
  // sector reads plus write-backs over all tests
  localparam int TRANSFERS   = 20;
  localparam int WATCHDOG_NS = TRANSFERS * 600 * BUSY_LONG * 10;

  logic       clk;
  logic       rst;
  int         busy_max;
  logic       spi_rst;
  logic       spi_r_block;
  logic       spi_r_byte;
  logic       spi_w_block;
  logic       spi_w_byte;
  logic       spi_busy;
  sd_addr_t   spi_addr;
  byte_t      spi_data_in;
  byte_t      spi_data_out;
  logic       uut_rst;
  logic       uut_decrypt;
  logic       uut_end_enc;
  logic       uut_end_dec;
  block_t     uut_block_to;
  block_t     uut_block_from;
  key_t       uut_key;
  logic       done;
  err_count_t error_count;

  int     errors;
  int     checks;
  int     low_cycles;
  int     run_lengths [$];
  int     vec_count;
  block_t vec_block [4];
  key_t   vec_key [4];
  bit     vec_dec [4];
  block_t vec_exp [4];
  int     vec_errors;
  byte_t  snapshot [8*SECTOR_BYTES];

  sd_autotest dut0 (
    .clk              (clk),
    .rst              (rst),
    .spi_rst_o        (spi_rst),
    .spi_r_block_o    (spi_r_block),
    .spi_r_byte_o     (spi_r_byte),
    .spi_w_block_o    (spi_w_block),
    .spi_w_byte_o     (spi_w_byte),
    .spi_block_addr_o (spi_addr),
    .spi_data_in_o    (spi_data_in),
    .spi_busy_i       (spi_busy),
    .spi_data_out_i   (spi_data_out),
    .uut_rst_o        (uut_rst),
    .uut_block_o      (uut_block_to),
    .uut_key_o        (uut_key),
    .uut_decrypt_o    (uut_decrypt),
    .uut_block_i      (uut_block_from),
    .uut_end_enc_i    (uut_end_enc),
    .uut_end_dec_i    (uut_end_dec),
    .done_o           (done),
    .error_count_o    (error_count)
  );

  sd_host_model host0 (
    .clk          (clk),
    .spi_rst_i    (spi_rst),
    .r_block_i    (spi_r_block),
    .r_byte_i     (spi_r_byte),
    .w_block_i    (spi_w_block),
    .w_byte_i     (spi_w_byte),
    .block_addr_i (spi_addr),
    .data_in_i    (spi_data_in),
    .busy_max_i   (busy_max),
    .busy_o       (spi_busy),
    .data_out_o   (spi_data_out)
  );

  cipher_stub cipher0 (
    .clk       (clk),
    .rst       (uut_rst),
    .block_i   (uut_block_to),
    .key_i     (uut_key),
    .decrypt_i (uut_decrypt),
    .block_o   (uut_block_from),
    .end_enc_o (uut_end_enc),
    .end_dec_o (uut_end_dec)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // cipher run lengths as seen at the uut_rst_o port
  always @(negedge clk) begin
    if (rst) begin
      low_cycles = 0;
    end else if (!uut_rst) begin
      low_cycles++;
    end else if (low_cycles != 0) begin
      run_lengths.push_back(low_cycles);
      low_cycles = 0;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the sequencer reported done");
    $display("Something failed");
    $finish;
  end

  function automatic byte_t fill_pattern(int a);
    return byte_t'(a) ^ byte_t'(a >> 4);
  endfunction

  function automatic block_t cipher_result(block_t blk, key_t key, bit dec);
    return dec ? (blk ^ key[79:16]) : (blk ^ key[63:0]);
  endfunction

  // first 47 bytes of a sector with byte 0 in the low bits
  function automatic logic [375:0] sector_image(int s, cycle_count_t cyc);
    block_t res;
    res = cipher_result(vec_block[s], vec_key[s], vec_dec[s]);
    return {cyc, res, vec_exp[s], 7'b0, vec_dec[s], vec_key[s], vec_block[s], 32'hDDCC_BBAA};
  endfunction

  task automatic expect_equal(string name, logic [63:0] got, logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Error: %s = %h, expected %h", name, got, exp);
    end
  endtask

  task automatic fill_memory();
    vec_count  = 0;
    vec_errors = 0;
    for (int a = 0; a < 8*SECTOR_BYTES; a++) begin
      host0.mem[a] = fill_pattern(a);
    end
  endtask

  task automatic add_vector(block_t blk, key_t key, bit dec, bit right);
    logic [375:0] img;
    int           s;
    s = vec_count;
    vec_block[s] = blk;
    vec_key[s]   = key;
    vec_dec[s]   = dec;
    vec_exp[s]   = cipher_result(blk, key, dec) ^ (right ? 64'h0 : 64'h1);
    if (!right) vec_errors++;
    img = sector_image(s, '0);
    for (int i = 0; i < OFS_RESULT; i++) begin
      host0.mem[s*SECTOR_BYTES + i] = img[i*8 +: 8];
    end
    vec_count++;
  endtask

  task automatic run_dut(int max_delay);
    run_lengths.delete();
    busy_max = max_delay;
    @(negedge clk);
    rst = 1'b1;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    while (!done) @(negedge clk);
    // done_o has to stay up until the next reset
    repeat (20) @(negedge clk);
  endtask

  task automatic check_results();
    logic [375:0] img;
    byte_t        exp;
    int           a;
    checks++;
    assert (run_lengths.size() == vec_count) else begin
      errors++;
      $display("cipher ran %0d times for %0d vectors", run_lengths.size(), vec_count);
    end
    for (int s = 0; s < 8; s++) begin
      if (s < vec_count) img = sector_image(s, cycle_count_t'(run_lengths[s]));
      for (int i = 0; i < SECTOR_BYTES; i++) begin
        a = s*SECTOR_BYTES + i;
        if (s >= vec_count) exp = fill_pattern(a);
        else if (i < 47) exp = img[i*8 +: 8];
        else exp = '0;
        expect_equal($sformatf("spi_data_in_o (sector %0d byte %0d)", s, i), host0.mem[a], exp);
      end
    end
    expect_equal("error_count_o", error_count, vec_errors);
    expect_equal("done_o", done, 1);
  endtask

  task automatic load_chain();
    fill_memory();
    add_vector(64'hFEDC_BA98_7654_3210, 80'h0F1E_2D3C_4B5A_6978_8796, 1'b0, 1'b1);
    add_vector(64'h1357_9BDF_0246_8ACE, 80'hA5A5_5A5A_C3C3_3C3C_9696, 1'b1, 1'b0);
    add_vector(64'h0000_FFFF_1234_ABCD, 80'h7777_8888_9999_AAAA_BBBB, 1'b1, 1'b1);
  endtask

  task automatic test_encrypt_match();
    $display("test: encrypt vector, expected value right");
    fill_memory();
    add_vector(64'h0123_4567_89AB_CDEF, 80'h1111_2222_3333_4444_5555, 1'b0, 1'b1);
    run_dut(BUSY_SHORT);
    check_results();
  endtask

  task automatic test_decrypt_mismatch();
    $display("test: decrypt vector, expected value wrong");
    fill_memory();
    add_vector(64'hDEAD_BEEF_CAFE_F00D, 80'h0102_0304_0506_0708_090A, 1'b1, 1'b0);
    run_dut(BUSY_SHORT);
    check_results();
  endtask

  task automatic test_three_vectors();
    $display("test: three vectors then a bad signature");
    load_chain();
    run_dut(BUSY_SHORT);
    check_results();
    for (int a = 0; a < 8*SECTOR_BYTES; a++) begin
      snapshot[a] = host0.mem[a];
    end
  endtask

  task automatic test_long_busy();
    $display("test: same vectors with long busy stretches");
    load_chain();
    run_dut(BUSY_LONG);
    check_results();
    for (int a = 0; a < 8*SECTOR_BYTES; a++) begin
      expect_equal($sformatf("sector memory (address %0d)", a), host0.mem[a], snapshot[a]);
    end
  endtask

  initial begin
    rst       = 1'b1;
    busy_max  = BUSY_SHORT;
    errors    = 0;
    checks    = 0;
    vec_count = 0;
    test_encrypt_match();
    test_decrypt_mismatch();
    test_three_vectors();
    test_long_busy();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- hdl/autotest_ctrl.sv
// autotest controller: sector read, cipher run and write-back sequencing
`timescale 1ns/10ps

module autotest_ctrl (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          spi_busy_i,
  input  logic                          sig_match_i,
  input  logic                          mismatch_i,
  input  logic                          decrypt_i,
  input  logic                          uut_end_enc_i,
  input  logic                          uut_end_dec_i,
  output logic                          spi_rst_o,
  output logic                          spi_r_block_o,
  output logic                          spi_r_byte_o,
  output logic                          spi_w_block_o,
  output logic                          spi_w_byte_o,
  output sd_autotest_pkg::sd_addr_t     spi_block_addr_o,
  output sd_autotest_pkg::byte_idx_t    byte_idx_o,
  output logic                          clear_o,
  output logic                          capture_o,
  output logic                          result_capture_o,
  output sd_autotest_pkg::cycle_count_t run_cycles_o,
  output logic                          uut_rst_o,
  output logic                          done_o,
  output sd_autotest_pkg::err_count_t   error_count_o
);

  import sd_autotest_pkg::*;

  ctrl_state_e state, state_nxt;
  logic        last_byte;
  logic        run_end;

  assign last_byte = (byte_idx_o == byte_idx_t'(SECTOR_BYTES - 1));
  assign run_end   = decrypt_i ? uut_end_dec_i : uut_end_enc_i;

  always_comb begin
    state_nxt        = state;
    spi_rst_o        = 1'b0;
    spi_r_block_o    = 1'b0;
    spi_r_byte_o     = 1'b0;
    spi_w_block_o    = 1'b0;
    spi_w_byte_o     = 1'b0;
    clear_o          = 1'b0;
    capture_o        = 1'b0;
    result_capture_o = 1'b0;
    uut_rst_o        = 1'b1;
    done_o           = 1'b0;
    case (state)
      RESET_HOST: begin
        spi_rst_o = 1'b1;
        if (spi_busy_i) state_nxt = WAIT_HOST;
      end
      WAIT_HOST: if (!spi_busy_i) state_nxt = IDLE;
      IDLE: begin
        clear_o = 1'b1;
        if (!spi_busy_i) state_nxt = REQ_READ;
      end
      REQ_READ: begin
        spi_r_block_o = 1'b1;
        if (spi_busy_i) state_nxt = WAIT_READ;
      end
      WAIT_READ: begin
        spi_r_block_o = 1'b1;
        if (!spi_busy_i) state_nxt = CAPTURE;
      end
      CAPTURE: begin
        spi_r_block_o = 1'b1;
        capture_o     = 1'b1;
        state_nxt     = last_byte ? CHECK_SIG : REQ_BYTE;
      end
      REQ_BYTE: begin
        spi_r_block_o = 1'b1;
        spi_r_byte_o  = 1'b1;
        if (spi_busy_i) state_nxt = WAIT_BYTE;
      end
      WAIT_BYTE: begin
        spi_r_block_o = 1'b1;
        if (!spi_busy_i) state_nxt = CAPTURE;
      end
      CHECK_SIG: state_nxt = sig_match_i ? RUN : DONE;
      RUN: begin
        uut_rst_o = 1'b0;
        if (run_end) begin
          result_capture_o = 1'b1;
          state_nxt        = COMPARE;
        end
      end
      COMPARE: state_nxt = REQ_WRITE;
      REQ_WRITE: begin
        spi_w_block_o = 1'b1;
        if (spi_busy_i) state_nxt = WAIT_WRITE;
      end
      WAIT_WRITE: begin
        spi_w_block_o = 1'b1;
        if (!spi_busy_i) state_nxt = PUT_BYTE;
      end
      PUT_BYTE: begin
        spi_w_block_o = 1'b1;
        spi_w_byte_o  = 1'b1;
        if (spi_busy_i) state_nxt = WAIT_PUT;
      end
      WAIT_PUT: begin
        spi_w_block_o = 1'b1;
        if (!spi_busy_i) state_nxt = last_byte ? NEXT_BLOCK : PUT_BYTE;
      end
      // w_block drops here, host commits the sector
      NEXT_BLOCK: state_nxt = IDLE;
      DONE: done_o = 1'b1;
      default: state_nxt = RESET_HOST;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state            <= RESET_HOST;
      byte_idx_o       <= '0;
      spi_block_addr_o <= START_BLOCK;
      run_cycles_o     <= '0;
      error_count_o    <= '0;
    end else begin
      state <= state_nxt;
      case (state)
        IDLE: byte_idx_o <= '0;
        REQ_BYTE: if (spi_busy_i) byte_idx_o <= byte_idx_o + 1'b1;
        // count includes the cycle being spent in RUN
        CHECK_SIG: run_cycles_o <= cycle_count_t'(1);
        RUN: run_cycles_o <= run_cycles_o + 1'b1;
        COMPARE: begin
          byte_idx_o <= '0;
          if (mismatch_i) error_count_o <= error_count_o + 1'b1;
        end
        WAIT_PUT: begin
          if (!spi_busy_i && !last_byte) byte_idx_o <= byte_idx_o + 1'b1;
        end
        NEXT_BLOCK: spi_block_addr_o <= spi_block_addr_o + 1'b1;
        default: ;
      endcase
    end
  end

endmodule

//--- hdl/result_writer.sv
// result writer: holds cipher result and cycle count, builds the write-back sector
`timescale 1ns/10ps

module result_writer (
  input  logic                          clk,
  input  logic                          capture_i,
  input  sd_autotest_pkg::cycle_count_t run_cycles_i,
  input  sd_autotest_pkg::block_t       result_i,
  input  sd_autotest_pkg::block_t       block_i,
  input  sd_autotest_pkg::key_t         key_i,
  input  logic                          decrypt_i,
  input  sd_autotest_pkg::block_t       expected_i,
  input  sd_autotest_pkg::byte_idx_t    byte_idx_i,
  output logic                          mismatch_o,
  output sd_autotest_pkg::byte_t        byte_o
);

  import sd_autotest_pkg::*;

  block_t       result_q;
  cycle_count_t cycles_q;

  always_ff @(posedge clk) begin
    if (capture_i) begin
      result_q <= result_i;
      cycles_q <= run_cycles_i;
    end
  end

  assign mismatch_o = (result_q != expected_i);

  // byte mux, anything past the cycle field goes out as zero
  always_comb begin
    byte_o = '0;
    for (int i = 0; i < SIG_BYTES; i++) begin
      if (byte_idx_i == byte_idx_t'(i))
        byte_o = SIGNATURE[(SIG_BYTES-1-i)*8 +: 8];
    end
    for (int i = 0; i < BLOCK_BYTES; i++) begin
      if (byte_idx_i == byte_idx_t'(OFS_BLOCK + i))
        byte_o = block_i[i*8 +: 8];
      if (byte_idx_i == byte_idx_t'(OFS_EXPECTED + i))
        byte_o = expected_i[i*8 +: 8];
      if (byte_idx_i == byte_idx_t'(OFS_RESULT + i))
        byte_o = result_q[i*8 +: 8];
    end
    for (int i = 0; i < KEY_BYTES; i++) begin
      if (byte_idx_i == byte_idx_t'(OFS_KEY + i))
        byte_o = key_i[i*8 +: 8];
    end
    for (int i = 0; i < CYCLE_BYTES; i++) begin
      if (byte_idx_i == byte_idx_t'(OFS_CYCLES + i))
        byte_o = cycles_q[i*8 +: 8];
    end
    if (byte_idx_i == OFS_MODE)
      byte_o = {7'b0, decrypt_i};
  end

endmodule

//--- hdl/sd_autotest.sv
// sd autotest top: cipher self-test sequencer between an SPI SD host and the cipher
`timescale 1ns/10ps

module sd_autotest (
  input  logic                        clk,
  input  logic                        rst,
  // SPI SD host
  output logic                        spi_rst_o,
  output logic                        spi_r_block_o,
  output logic                        spi_r_byte_o,
  output logic                        spi_w_block_o,
  output logic                        spi_w_byte_o,
  output sd_autotest_pkg::sd_addr_t   spi_block_addr_o,
  output sd_autotest_pkg::byte_t      spi_data_in_o,
  input  logic                        spi_busy_i,
  input  sd_autotest_pkg::byte_t      spi_data_out_i,
  // cipher
  output logic                        uut_rst_o,
  output sd_autotest_pkg::block_t     uut_block_o,
  output sd_autotest_pkg::key_t       uut_key_o,
  output logic                        uut_decrypt_o,
  input  sd_autotest_pkg::block_t     uut_block_i,
  input  logic                        uut_end_enc_i,
  input  logic                        uut_end_dec_i,
  // status
  output logic                        done_o,
  output sd_autotest_pkg::err_count_t error_count_o
);

  import sd_autotest_pkg::*;

  byte_idx_t    byte_idx;
  cycle_count_t run_cycles;
  block_t       expected;
  logic         clear;
  logic         capture;
  logic         result_capture;
  logic         sig_match;
  logic         mismatch;

  autotest_ctrl u_ctrl (
    .clk              (clk),
    .rst              (rst),
    .spi_busy_i       (spi_busy_i),
    .sig_match_i      (sig_match),
    .mismatch_i       (mismatch),
    .decrypt_i        (uut_decrypt_o),
    .uut_end_enc_i    (uut_end_enc_i),
    .uut_end_dec_i    (uut_end_dec_i),
    .spi_rst_o        (spi_rst_o),
    .spi_r_block_o    (spi_r_block_o),
    .spi_r_byte_o     (spi_r_byte_o),
    .spi_w_block_o    (spi_w_block_o),
    .spi_w_byte_o     (spi_w_byte_o),
    .spi_block_addr_o (spi_block_addr_o),
    .byte_idx_o       (byte_idx),
    .clear_o          (clear),
    .capture_o        (capture),
    .result_capture_o (result_capture),
    .run_cycles_o     (run_cycles),
    .uut_rst_o        (uut_rst_o),
    .done_o           (done_o),
    .error_count_o    (error_count_o)
  );

  vector_loader u_loader (
    .clk         (clk),
    .clear_i     (clear),
    .capture_i   (capture),
    .byte_idx_i  (byte_idx),
    .byte_i      (spi_data_out_i),
    .sig_match_o (sig_match),
    .block_o     (uut_block_o),
    .key_o       (uut_key_o),
    .decrypt_o   (uut_decrypt_o),
    .expected_o  (expected)
  );

  result_writer u_writer (
    .clk          (clk),
    .capture_i    (result_capture),
    .run_cycles_i (run_cycles),
    .result_i     (uut_block_i),
    .block_i      (uut_block_o),
    .key_i        (uut_key_o),
    .decrypt_i    (uut_decrypt_o),
    .expected_i   (expected),
    .byte_idx_i   (byte_idx),
    .mismatch_o   (mismatch),
    .byte_o       (spi_data_in_o)
  );

endmodule

//--- hdl/sd_autotest_pkg.sv
// sd autotest package: widths, sector layout and controller states
package sd_autotest_pkg;

  localparam int BLOCK_W = 64;
  localparam int KEY_W   = 80;

  typedef logic [7:0]         byte_t;
  typedef logic [BLOCK_W-1:0] block_t;
  typedef logic [KEY_W-1:0]   key_t;
  typedef logic [31:0]        sd_addr_t;
  typedef logic [9:0]         byte_idx_t;
  typedef logic [63:0]        cycle_count_t;
  typedef logic [31:0]        err_count_t;

  localparam int BLOCK_BYTES = BLOCK_W / 8;
  localparam int KEY_BYTES   = KEY_W / 8;
  localparam int CYCLE_BYTES = $bits(cycle_count_t) / 8;
  localparam int SIG_BYTES   = 4;

  localparam int          SECTOR_BYTES = 512;
  localparam sd_addr_t    START_BLOCK  = 32'h0010_0000;
  localparam logic [31:0] SIGNATURE    = 32'hAABB_CCDD;

  // sector layout, multi-byte fields little-endian
  localparam byte_idx_t OFS_BLOCK    = 10'd4;
  localparam byte_idx_t OFS_KEY      = 10'd12;
  localparam byte_idx_t OFS_MODE     = 10'd22;
  localparam byte_idx_t OFS_EXPECTED = 10'd23;
  localparam byte_idx_t OFS_RESULT   = 10'd31;
  localparam byte_idx_t OFS_CYCLES   = 10'd39;

  typedef enum logic [4:0] {
    RESET_HOST,
    WAIT_HOST,
    IDLE,
    REQ_READ,
    WAIT_READ,
    CAPTURE,
    REQ_BYTE,
    WAIT_BYTE,
    CHECK_SIG,
    RUN,
    COMPARE,
    REQ_WRITE,
    WAIT_WRITE,
    PUT_BYTE,
    WAIT_PUT,
    NEXT_BLOCK,
    DONE
  } ctrl_state_e;

endpackage

//--- hdl/vector_loader.sv
// vector loader: assembles signature and cipher test vector from sector bytes
`timescale 1ns/10ps

module vector_loader (
  input  logic                       clk,
  input  logic                       clear_i,
  input  logic                       capture_i,
  input  sd_autotest_pkg::byte_idx_t byte_idx_i,
  input  sd_autotest_pkg::byte_t     byte_i,
  output logic                       sig_match_o,
  output sd_autotest_pkg::block_t    block_o,
  output sd_autotest_pkg::key_t      key_o,
  output logic                       decrypt_o,
  output sd_autotest_pkg::block_t    expected_o
);

  import sd_autotest_pkg::*;

  logic [31:0] sig_q;

  always_ff @(posedge clk) begin
    if (clear_i) begin
      sig_q      <= '0;
      block_o    <= '0;
      key_o      <= '0;
      decrypt_o  <= 1'b0;
      expected_o <= '0;
    end else if (capture_i) begin
      // signature is big-endian, byte 0 is the top byte
      for (int i = 0; i < SIG_BYTES; i++) begin
        if (byte_idx_i == byte_idx_t'(i))
          sig_q[(SIG_BYTES-1-i)*8 +: 8] <= byte_i;
      end
      for (int i = 0; i < BLOCK_BYTES; i++) begin
        if (byte_idx_i == byte_idx_t'(OFS_BLOCK + i))
          block_o[i*8 +: 8] <= byte_i;
        if (byte_idx_i == byte_idx_t'(OFS_EXPECTED + i))
          expected_o[i*8 +: 8] <= byte_i;
      end
      for (int i = 0; i < KEY_BYTES; i++) begin
        if (byte_idx_i == byte_idx_t'(OFS_KEY + i))
          key_o[i*8 +: 8] <= byte_i;
      end
      // only bit 0 of the mode byte matters
      if (byte_idx_i == OFS_MODE)
        decrypt_o <= byte_i[0];
    end
  end

  assign sig_match_o = (sig_q == SIGNATURE);

endmodule

//--- sd_autotest.f
hdl/sd_autotest_pkg.sv
hdl/vector_loader.sv
hdl/result_writer.sv
hdl/autotest_ctrl.sv
hdl/sd_autotest.sv
bench/sd_host_model.sv
bench/cipher_stub.sv
bench/tb_sd_autotest.sv
